//--- hdl/bp_stats_apb.sv
`timescale 1ns/1ps
`default_nettype none

module bp_stats_apb #(
    parameter int hist_bits = 4
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire lc3b_pkg::apb_addr_t  paddr,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire lc3b_pkg::apb_data_t  pwdata,
    output lc3b_pkg::apb_data_t       prdata,
    output logic                      pready,
    output logic                      pslverr,
    branch_resolve_if.sink            resolve,
    input  wire logic                 update,
    input  wire logic [hist_bits-1:0] history,
    output logic                      enable
);
    import lc3b_pkg::*;

    logic      access;
    logic      addr_ok;
    logic      addr_ro;
    logic      ctrl_wr;
    logic      clear;
    logic      mispredict;
    apb_data_t rd_value;
    apb_data_t branch_cnt;
    apb_data_t mispredict_cnt;

    // access phase of an APB transfer
    assign access = psel & penable;

    // no wait states
    assign pready = 1'b1;

    // register decode
    always_comb begin
        addr_ok  = 1'b1;
        addr_ro  = 1'b1;
        rd_value = '0;
        case (paddr)
            reg_ctrl: begin
                // clear bit is a strobe and always reads back as 0
                addr_ro  = 1'b0;
                rd_value = apb_data_t'(enable);
            end
            reg_branches:    rd_value = branch_cnt;
            reg_mispredicts: rd_value = mispredict_cnt;
            reg_history:     rd_value = apb_data_t'(history);
            default: begin
                addr_ok = 1'b0;
                addr_ro = 1'b0;
            end
        endcase
    end

    // unmapped offsets and writes to the counters are errors
    assign pslverr = access & (~addr_ok | (pwrite & addr_ro));

    // read data only while a good read is in its access phase
    assign prdata = (access & ~pwrite & addr_ok) ? rd_value : '0;

    assign ctrl_wr = access & pwrite & (paddr == reg_ctrl);
    assign clear   = ctrl_wr & pwdata[1];

    // the stats do not re-check the opcode, update already did
    assign mispredict = resolve.taken ^ resolve.predicted;

    // enable comes up set so the predictor trains out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b1;
        end else if (ctrl_wr) begin
            enable <= pwdata[0];
        end
    end

    // 32-bit counts that wrap
    // clear wins over a branch on the same edge
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            branch_cnt     <= '0;
            mispredict_cnt <= '0;
        end else if (update) begin
            branch_cnt <= branch_cnt + 32'd1;
            if (mispredict) begin
                mispredict_cnt <= mispredict_cnt + 32'd1;
            end
        end
    end

    // master never raises penable outside a selected transfer
    assert property (@(posedge clk) disable iff (rst)
        penable |-> psel);

    // setup phase is followed by its access phase with the same address
    assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> (psel && penable && $stable(paddr)));

endmodule

`default_nettype wire

//--- hdl/bp_top.sv
`timescale 1ns/1ps
`default_nettype none

module bp_top #(
    parameter int hist_bits  = 4,
    parameter int index_bits = 5
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    // decode stage
    input  wire lc3b_pkg::lc3b_word   pc_id,
    output logic                      predict_taken,
    output logic [hist_bits-1:0]      hist_id,
    // writeback stage
    input  wire logic                 wb_valid,
    input  wire lc3b_pkg::lc3b_word   wb_pc,
    input  wire lc3b_pkg::lc3b_opcode wb_opcode,
    input  wire logic                 wb_taken,
    input  wire logic                 wb_predicted,
    input  wire logic [hist_bits-1:0] wb_hist,
    // APB slave
    input  wire lc3b_pkg::apb_addr_t  paddr,
    input  wire logic                 psel,
    input  wire logic                 penable,
    input  wire logic                 pwrite,
    input  wire lc3b_pkg::apb_data_t  pwdata,
    output lc3b_pkg::apb_data_t       prdata,
    output logic                      pready,
    output logic                      pslverr
);
    import lc3b_pkg::*;

    logic                  enable;
    logic                  update;
    logic                  write;
    logic [hist_bits-1:0]  history;
    logic [index_bits-1:0] rd_index;
    logic [index_bits-1:0] wr_index;
    bp_counter_t           wr_data;
    bp_counter_t           rd_data;
    bp_counter_t           old_data;

    branch_resolve_if #(.hist_bits(hist_bits)) resolve_bus ();

    // the top plays the source side of the resolution bus
    assign resolve_bus.valid     = wb_valid;
    assign resolve_bus.pc        = wb_pc;
    assign resolve_bus.opcode    = wb_opcode;
    assign resolve_bus.taken     = wb_taken;
    assign resolve_bus.predicted = wb_predicted;
    assign resolve_bus.hist      = wb_hist;

    branch_predictor #(
        .hist_bits  (hist_bits),
        .index_bits (index_bits)
    ) i_branch_predictor (
        .clk           (clk),
        .rst           (rst),
        .enable        (enable),
        .pc_id         (pc_id),
        .resolve       (resolve_bus.sink),
        .rd_data       (rd_data),
        .old_data      (old_data),
        .rd_index      (rd_index),
        .wr_index      (wr_index),
        .write         (write),
        .wr_data       (wr_data),
        .update        (update),
        .predict_taken (predict_taken),
        .hist_id       (hist_id),
        .history       (history)
    );

    pattern_table #(
        .index_bits (index_bits)
    ) i_pattern_table (
        .clk      (clk),
        .rst      (rst),
        .write    (write),
        .rd_index (rd_index),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .old_data (old_data)
    );

    bp_stats_apb #(
        .hist_bits (hist_bits)
    ) i_bp_stats_apb (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .resolve (resolve_bus.sink),
        .update  (update),
        .history (history),
        .enable  (enable)
    );

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor #(
    parameter int hist_bits  = 4,
    parameter int index_bits = 5
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  enable,
    input  wire lc3b_pkg::lc3b_word    pc_id,
    branch_resolve_if.sink             resolve,
    input  wire lc3b_pkg::bp_counter_t rd_data,
    input  wire lc3b_pkg::bp_counter_t old_data,
    output logic [index_bits-1:0]      rd_index,
    output logic [index_bits-1:0]      wr_index,
    output logic                       write,
    output lc3b_pkg::bp_counter_t      wr_data,
    output logic                       update,
    output logic                       predict_taken,
    output logic [hist_bits-1:0]       hist_id,
    output logic [hist_bits-1:0]       history
);
    import lc3b_pkg::*;

    // history after shifting in the resolved outcome
    logic [hist_bits-1:0] history_next;

    // the hash lines history up with the top of the index
    if (index_bits < hist_bits) begin : g_bad_widths
        $error("branch_predictor needs index_bits >= hist_bits");
    end

    // gshare hash
    // PC bits index_bits..1 form the index
    // bit 0 is always 0 on LC-3b
    // the history is xored into the upper hist_bits of that
    function automatic logic [index_bits-1:0] gshare_index(
        input lc3b_word             pc,
        input logic [hist_bits-1:0] hist
    );
        logic [index_bits-1:0] base;
        logic [index_bits-1:0] hist_up;
        base    = pc[index_bits:1];
        hist_up = index_bits'(hist) << (index_bits - hist_bits);
        return base ^ hist_up;
    endfunction

    // decode hashes with the live history register
    assign rd_index = gshare_index(pc_id, history);

    // writeback hashes with the history that decode used back then
    assign wr_index = gshare_index(resolve.pc, resolve.hist);

    // only resolved conditional branches train and only when enabled
    assign update = enable & resolve.valid & (resolve.opcode == op_br);
    assign write  = update;

    // saturating step of the counter read at the writeback index
    always_comb begin
        wr_data = old_data;
        if (resolve.taken) begin
            if (old_data != 2'd3) begin
                wr_data = bp_counter_t'(old_data + 2'd1);
            end
        end else begin
            if (old_data != 2'd0) begin
                wr_data = bp_counter_t'(old_data - 2'd1);
            end
        end
    end

    // upper bit set means counter is 2 or 3
    assign predict_taken = rd_data[1];

    // the pipeline carries this down to writeback with the guess
    assign hist_id = history;

    // shift left with the newest outcome in bit 0
    // oldest outcome falls off the top
    assign history_next = hist_bits'({history, resolve.taken});

    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (update) begin
            history <= history_next;
        end
    end

    // the training strobe is never unknown out of reset
    assert property (@(posedge clk) disable iff (rst)
        !$isunknown(update));

    // a training branch brings known fields into the table and history
    assert property (@(posedge clk) disable iff (rst)
        update |-> !$isunknown({resolve.pc, resolve.hist, resolve.taken, old_data}));

endmodule

`default_nettype wire

//--- hdl/branch_resolve_if.sv
`timescale 1ns/1ps
`default_nettype none

interface branch_resolve_if #(
    parameter int hist_bits = 4
);
    import lc3b_pkg::*;

    // one instruction leaving writeback
    logic                 valid;
    lc3b_word             pc;
    lc3b_opcode           opcode;
    // real outcome of the branch
    logic                 taken;
    // guess and history that decode handed down the pipe
    logic                 predicted;
    logic [hist_bits-1:0] hist;

    // writeback side
    modport source (
        output valid, pc, opcode, taken, predicted, hist
    );

    // predictor and statistics side
    modport sink (
        input valid, pc, opcode, taken, predicted, hist
    );

endinterface

`default_nettype wire

//--- hdl/lc3b_pkg.sv
`default_nettype none

package lc3b_pkg;

    // machine word of the LC-3b, used for every PC in the predictor
    typedef logic [15:0] lc3b_word;

    // instruction opcode field, bits 15:12 of the instruction
    typedef logic [3:0] lc3b_opcode;

    // conditional branch BR, the only opcode that trains the predictor
    localparam lc3b_opcode op_br = 4'b0000;

    // two-bit saturating counter held in each pattern table entry
    // 0 strongly not taken, 1 weakly not taken
    // 2 weakly taken, 3 strongly taken
    typedef logic [1:0] bp_counter_t;

    // every entry comes out of reset here
    localparam bp_counter_t ctr_weak_nt = 2'd1;

    // APB address and data
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map of the statistics block
    // enable in bit 0, clear strobe in bit 1
    localparam apb_addr_t reg_ctrl        = 8'h00;
    // resolved conditional branches
    localparam apb_addr_t reg_branches    = 8'h04;
    // resolved branches whose guess was wrong
    localparam apb_addr_t reg_mispredicts = 8'h08;
    // current global history, zero extended
    localparam apb_addr_t reg_history     = 8'h0C;

endpackage

`default_nettype wire

//--- hdl/pattern_table.sv
`timescale 1ns/1ps
`default_nettype none

module pattern_table #(
    parameter int index_bits = 5
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  write,
    input  wire logic [index_bits-1:0] rd_index,
    input  wire logic [index_bits-1:0] wr_index,
    input  wire lc3b_pkg::bp_counter_t wr_data,
    output lc3b_pkg::bp_counter_t      rd_data,
    output lc3b_pkg::bp_counter_t      old_data
);
    import lc3b_pkg::*;

    localparam int depth = 1 << index_bits;

    // one counter per gshare index
    bp_counter_t ctr_mem [depth];

    // decode port
    // asynchronous, so a same-cycle write is not yet visible here
    assign rd_data = ctr_mem[rd_index];

    // read half of the writeback read-modify-write
    assign old_data = ctr_mem[wr_index];

    // whole table goes back to weakly not taken on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                ctr_mem[i] <= ctr_weak_nt;
            end
        end else if (write) begin
            ctr_mem[wr_index] <= wr_data;
        end
    end

    // an X index on a write would corrupt an unknown entry
    // and the decode read of the same cycle would be just as bad
    assert property (@(posedge clk) disable iff (rst)
        write |-> !$isunknown({wr_index, rd_index}));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the gshare predictor testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_bp_top -f tb.f -o tb_bp_top \
    && ./obj_dir/tb_bp_top 2>&1 | tee sim.log \
    || { echo "build or run error"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- tb.f
+incdir+include
hdl/lc3b_pkg.sv
hdl/branch_resolve_if.sv
hdl/pattern_table.sv
hdl/branch_predictor.sv
hdl/bp_stats_apb.sv
hdl/bp_top.sv
testbench/tb_bp_top.sv

//--- include/tb_bp_checks.svh
`ifndef TB_BP_CHECKS_SVH
`define TB_BP_CHECKS_SVH

// reference copy of the predictor and statistics state
logic [hist_bits-1:0] model_hist;
bp_counter_t          model_ctr [1 << index_bits];
logic                 model_enable;
apb_data_t            model_branches;
apb_data_t            model_mispredicts;
logic [31:0]          lfsr_state;
int                   errors;
int                   checks;

task automatic check_pred(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_hist(input string name, input logic [hist_bits-1:0] got,
                          input logic [hist_bits-1:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
endtask

task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
endtask

// galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit handed out
function automatic logic take_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
endfunction

function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[14:0], take_bit()};
    end
    return v;
endfunction

// pc bits index_bits..1, history xored into the top of them
function automatic logic [index_bits-1:0] gshare_slot(input lc3b_word pc,
                                                      input logic [hist_bits-1:0] hist);
    return pc[index_bits:1] ^ {hist, {(index_bits - hist_bits){1'b0}}};
endfunction

// some pc that lands on slot under the live history
function automatic lc3b_word pc_for_slot(input logic [index_bits-1:0] slot);
    return lc3b_word'({slot ^ {model_hist, {(index_bits - hist_bits){1'b0}}}, 1'b0});
endfunction

// taken once the counter reaches 2
function automatic logic expect_taken(input lc3b_word pc);
    return model_ctr[gshare_slot(pc, model_hist)] >= 2'd2;
endfunction

function automatic void clear_model();
    model_hist        = '0;
    model_enable      = 1'b1;
    model_branches    = '0;
    model_mispredicts = '0;
    for (int i = 0; i < (1 << index_bits); i++) begin
        model_ctr[i] = ctr_weak_nt;
    end
endfunction

// saturating step, history shift and counts for one resolution
task automatic train_model(input lc3b_word pc, input lc3b_opcode op, input logic taken,
                           input logic guess, input logic [hist_bits-1:0] hist);
    logic [index_bits-1:0] slot;
    slot = gshare_slot(pc, hist);
    if (model_enable && op == op_br) begin
        if (taken && model_ctr[slot] != 2'd3) begin
            model_ctr[slot] = model_ctr[slot] + 2'd1;
        end else if (!taken && model_ctr[slot] != 2'd0) begin
            model_ctr[slot] = model_ctr[slot] - 2'd1;
        end
        model_hist     = {model_hist[hist_bits-2:0], taken};
        model_branches = model_branches + 32'd1;
        if (taken != guess) begin
            model_mispredicts = model_mispredicts + 32'd1;
        end
    end
endtask

`endif

//--- testbench/tb_bp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bp_top;
    import lc3b_pkg::*;

    localparam int hist_bits  = 4;
    localparam int index_bits = 5;
    // reset, sweep, training, 200 branches of six cycles, stats, enable, errors
    localparam int sched_cycles = 4 + 50 + 30 + 200 * 6 + 20 + 60 + 20;
    localparam int cycle_limit  = 4 * sched_cycles;

    logic                 clk;
    logic                 rst;
    lc3b_word             pc_id;
    logic                 predict_taken;
    logic [hist_bits-1:0] hist_id;
    logic                 wb_valid;
    lc3b_word             wb_pc;
    lc3b_opcode           wb_opcode;
    logic                 wb_taken;
    logic                 wb_predicted;
    logic [hist_bits-1:0] wb_hist;
    apb_addr_t            paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    apb_data_t            pwdata;
    apb_data_t            prdata;
    logic                 pready;
    logic                 pslverr;
    int                   cycles;

    `include "tb_bp_checks.svh"

    // default widths
    bp_top i_bp_top (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // setup then access phase
    // sampled in the low half of the access cycle
    task automatic apb_xfer(input apb_addr_t addr, input logic wr, input apb_data_t data,
                            output apb_data_t rd, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #5;
        rd  = prdata;
        err = pslverr;
        // no wait states on this slave
        check_pred("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, input string name, input apb_data_t exp,
                            input logic err_exp);
        apb_data_t rd;
        logic      err;
        apb_xfer(addr, 1'b0, '0, rd, err);
        check_pred("pslverr", err, err_exp);
        // read data is only defined for a good address
        if (!err_exp) begin
            check_data(name, rd, exp);
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic err_exp);
        apb_data_t rd;
        logic      err;
        apb_xfer(addr, 1'b1, data, rd, err);
        check_pred("pslverr", err, err_exp);
    endtask

    // decode looks up a pc
    // guess and history must match the model
    task automatic probe_decode(input lc3b_word pc);
        @(negedge clk);
        pc_id = pc;
        #5;
        check_pred("predict_taken", predict_taken, expect_taken(pc));
        check_hist("hist_id", hist_id, model_hist);
    endtask

    // one writeback cycle
    // taken by the DUT on the rising edge in between
    task automatic resolve_branch(input lc3b_word pc, input lc3b_opcode op, input logic taken,
                                  input logic guess, input logic [hist_bits-1:0] hist);
        @(negedge clk);
        wb_valid     = 1'b1;
        wb_pc        = pc;
        wb_opcode    = op;
        wb_taken     = taken;
        wb_predicted = guess;
        wb_hist      = hist;
        @(negedge clk);
        wb_valid = 1'b0;
        train_model(pc, op, taken, guess, hist);
    endtask

    task automatic after_reset();
        for (int i = 0; i < (1 << index_bits); i++) begin
            probe_decode(lc3b_word'(i * 2));
            check_pred("predict_taken", predict_taken, 1'b0);
        end
        check_hist("hist_id", hist_id, '0);
        apb_read(reg_branches, "BRANCHES", 32'd0, 1'b0);
        apb_read(reg_mispredicts, "MISPREDICTS", 32'd0, 1'b0);
        apb_read(reg_history, "HISTORY", 32'd0, 1'b0);
        apb_read(reg_ctrl, "CTRL", 32'd1, 1'b0);
    endtask

    // carried history stays zero so all updates hit one slot
    // the live history still shifts so the probe pc follows it
    task automatic train_one_index();
        lc3b_word              pc_train;
        logic [index_bits-1:0] slot;
        logic [7:0]            outcomes;
        logic [7:0]            expect_pred;
        pc_train = 16'h3024;
        slot     = gshare_slot(pc_train, '0);
        // outcomes T T T N N N N T
        // counter walks 2 3 3 2 1 0 0 1
        outcomes    = 8'b1110_0001;
        expect_pred = 8'b1111_0000;
        for (int i = 7; i >= 0; i--) begin
            resolve_branch(pc_train, op_br, outcomes[i], model_ctr[slot][1], '0);
            probe_decode(pc_for_slot(slot));
            check_pred("trained predict_taken", predict_taken, expect_pred[i]);
        end
    endtask

    task automatic random_sequence(input int count);
        lc3b_word             pc;
        lc3b_opcode           op;
        logic                 taken;
        logic                 guess;
        logic [hist_bits-1:0] hist_dec;
        for (int n = 0; n < count; n++) begin
            pc = lc3b_word'(take_bits(15) << 1);
            // about one in four is some other opcode
            if (take_bits(2) == 16'd3) begin
                op = lc3b_opcode'(take_bits(3) + 16'd1);
            end else begin
                op = op_br;
            end
            taken = take_bit();
            probe_decode(pc);
            guess    = expect_taken(pc);
            hist_dec = model_hist;
            resolve_branch(pc, op, taken, guess, hist_dec);
            apb_read(reg_history, "HISTORY", apb_data_t'(model_hist), 1'b0);
        end
    endtask

    task automatic stats_and_clear();
        apb_read(reg_branches, "BRANCHES", model_branches, 1'b0);
        apb_read(reg_mispredicts, "MISPREDICTS", model_mispredicts, 1'b0);
        // enable stays set while bit 1 zeroes both counts
        apb_write(reg_ctrl, 32'h3, 1'b0);
        model_branches    = '0;
        model_mispredicts = '0;
        apb_read(reg_branches, "BRANCHES", 32'd0, 1'b0);
        apb_read(reg_mispredicts, "MISPREDICTS", 32'd0, 1'b0);
        apb_read(reg_ctrl, "CTRL", 32'd1, 1'b0);
    endtask

    task automatic disabled_updates();
        lc3b_word             pc;
        logic [hist_bits-1:0] hist_before;
        apb_write(reg_ctrl, 32'h0, 1'b0);
        model_enable = 1'b0;
        apb_read(reg_ctrl, "CTRL", 32'd0, 1'b0);
        hist_before = model_hist;
        for (int n = 0; n < 10; n++) begin
            pc = lc3b_word'(take_bits(15) << 1);
            resolve_branch(pc, op_br, take_bit(), 1'b0, model_hist);
            probe_decode(pc);
        end
        apb_read(reg_history, "HISTORY", apb_data_t'(hist_before), 1'b0);
        apb_read(reg_branches, "BRANCHES", 32'd0, 1'b0);
        apb_read(reg_mispredicts, "MISPREDICTS", 32'd0, 1'b0);
        // back on so a taken branch guessed not taken counts as a miss
        apb_write(reg_ctrl, 32'h1, 1'b0);
        model_enable = 1'b1;
        resolve_branch(16'h0040, op_br, 1'b1, 1'b0, model_hist);
        apb_read(reg_history, "HISTORY",
                 apb_data_t'({hist_before[hist_bits-2:0], 1'b1}), 1'b0);
        apb_read(reg_branches, "BRANCHES", 32'd1, 1'b0);
        apb_read(reg_mispredicts, "MISPREDICTS", 32'd1, 1'b0);
    endtask

    task automatic bad_accesses();
        apb_read(8'h10, "prdata", 32'd0, 1'b1);
        apb_write(8'h10, 32'hffff_ffff, 1'b1);
        apb_write(reg_branches, 32'h0000_1234, 1'b1);
        // nothing moved
        apb_read(reg_branches, "BRANCHES", model_branches, 1'b0);
        apb_read(reg_mispredicts, "MISPREDICTS", model_mispredicts, 1'b0);
        apb_read(reg_ctrl, "CTRL", 32'd1, 1'b0);
    endtask

    initial begin
        rst          = 1'b1;
        pc_id        = '0;
        wb_valid     = 1'b0;
        wb_pc        = '0;
        wb_opcode    = op_br;
        wb_taken     = 1'b0;
        wb_predicted = 1'b0;
        wb_hist      = '0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        errors       = 0;
        checks       = 0;
        lfsr_state   = 32'h7f39;
        clear_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        after_reset();
        train_one_index();
        random_sequence(200);
        stats_and_clear();
        disabled_updates();
        bad_accesses();
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", cycle_limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire
